//--- Makefile
# Verilator build of the PS/2 receive testbench.

SRCS := $(shell grep -v '^+' flist.f)

.PHONY: all run clean

all: obj_dir/Vps2_rx_tb

obj_dir/Vps2_rx_tb: $(SRCS) flist.f
	verilator --binary --timing --assert -f flist.f --top-module ps2_rx_tb -o Vps2_rx_tb

# Passes only when the pass message shows up in the output.
run: obj_dir/Vps2_rx_tb
	@out="$$(./obj_dir/Vps2_rx_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- design/ps2_frame_ctrl.sv
`timescale 1ns/1ps

module ps2_frame_ctrl
    import ps2_pkg::*;
#(
    parameter int WATCHDOG_CYCLES = 2000
) (
    input  logic         clk,
    input  logic         arst_n,
    ps2_frame_if.ctrl    bus,
    output logic         frame_done,
    output logic         frame_error
);

    localparam int             WD_W      = $clog2(WATCHDOG_CYCLES + 1);
    localparam logic [WD_W-1:0] WD_RELOAD = WD_W'(WATCHDOG_CYCLES - 1);

    frame_state_e    state;
    frame_state_e    state_next;
    logic [WD_W-1:0] wd_cnt;
    logic            wd_expired;
    logic            in_data;
    logic            frame_good;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Next state, taken only on a sample strobe.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        state_next = state;
        case (state)
            st_start: begin
                if (!bus.data_bit) state_next = st_d0;  // Start bit.
            end
            st_d0, st_d1, st_d2, st_d3, st_d4, st_d5, st_d6, st_d7, st_parity: begin
                state_next = frame_state_e'(state + 4'd1);
            end
            st_stop:  state_next = st_start;
            default:  state_next = st_start;
        endcase
    end

    assign in_data    = (state >= st_d0) && (state <= st_d7);
    assign frame_good = bus.data_bit && bus.parity_ok;  // Stop bit high, odd parity.

    assign bus.clear    = bus.sample && (state == st_start) && !bus.data_bit;
    assign bus.shift_en = bus.sample && in_data;
    assign bus.par_en   = bus.sample && (state == st_parity);

    assign wd_expired = (state != st_start) && !bus.sample && (wd_cnt == '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_start;
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            frame_done  <= 1'b0;
            frame_error <= 1'b0;
            if (wd_expired) begin
                state       <= st_start;  // Stalled frame is dropped.
                frame_error <= 1'b1;
            end else if (bus.sample) begin
                state <= state_next;
                if (state == st_stop) begin
                    frame_done  <= frame_good;
                    frame_error <= !frame_good;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Watchdog.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wd_cnt <= WD_RELOAD;
        end else if (bus.sample || state == st_start) begin
            wd_cnt <= WD_RELOAD;
        end else if (wd_cnt != '0) begin
            wd_cnt <= wd_cnt - 1'b1;
        end
    end

endmodule

//--- design/ps2_frame_if.sv
`timescale 1ns/1ps

interface ps2_frame_if;

    logic sample;     // Falling edge of the filtered PS/2 clock.
    logic data_bit;   // Filtered data line.
    logic shift_en;
    logic par_en;
    logic clear;
    logic parity_ok;

    modport ctrl (
        input  sample,
        input  data_bit,
        input  parity_ok,
        output shift_en,
        output par_en,
        output clear
    );

    modport shift (
        input  data_bit,
        input  shift_en,
        input  par_en,
        input  clear,
        output parity_ok
    );

endinterface

//--- design/ps2_frame_shift.sv
`timescale 1ns/1ps

module ps2_frame_shift (
    input  logic        clk,
    input  logic        arst_n,
    ps2_frame_if.shift  bus,
    output logic [7:0]  data_byte
);

    logic parity_acc;

    // Bits arrive LSB first, so each one enters at the top.
    always_ff @(posedge clk) begin
        if (bus.clear) begin
            data_byte <= '0;
        end else if (bus.shift_en) begin
            data_byte <= {bus.data_bit, data_byte[7:1]};
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Running parity over eight data bits and the parity bit.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            parity_acc <= 1'b0;
        end else if (bus.clear) begin
            parity_acc <= 1'b0;
        end else if (bus.shift_en || bus.par_en) begin
            parity_acc <= parity_acc ^ bus.data_bit;
        end
    end

    assign bus.parity_ok = parity_acc;  // High for an odd count of ones.

endmodule

//--- design/ps2_line_sync.sv
`timescale 1ns/1ps

module ps2_line_sync #(
    parameter int SYNC_STAGES = 2,
    parameter int FILTER_LEN  = 8
) (
    input  logic clk,
    input  logic arst_n,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic sample,
    output logic data_bit
);

    localparam int              CNT_W    = $clog2(FILTER_LEN + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FILTER_LEN - 1);

    logic [1:0] pin;
    logic [1:0] filt;
    logic       clk_prev;

    assign pin = {ps2_data, ps2_clk};  // Bit 0 clock, bit 1 data.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Per line: synchronizer, then a run-length filter.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar i = 0; i < 2; i++) begin : g_line
        logic [SYNC_STAGES-1:0] sync_q;
        logic [CNT_W-1:0]       cnt;
        logic                   filt_q;

        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                sync_q <= '1;  // Lines idle high.
                cnt    <= '0;
                filt_q <= 1'b1;
            end else begin
                sync_q <= {sync_q[SYNC_STAGES-2:0], pin[i]};
                if (sync_q[SYNC_STAGES-1] != filt_q) begin
                    if (cnt == CNT_LAST) begin
                        filt_q <= sync_q[SYNC_STAGES-1];
                        cnt    <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end else begin
                    cnt <= '0;  // Glitch ended, start over.
                end
            end
        end

        assign filt[i] = filt_q;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) clk_prev <= 1'b1;
        else         clk_prev <= filt[0];
    end

    assign sample   = clk_prev & ~filt[0];
    assign data_bit = filt[1];

endmodule

//--- design/ps2_pkg.sv
package ps2_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame states, one per bit of the 11-bit frame.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        st_start  = 4'd0,
        st_d0     = 4'd1,
        st_d1     = 4'd2,
        st_d2     = 4'd3,
        st_d3     = 4'd4,
        st_d4     = 4'd5,
        st_d5     = 4'd6,
        st_d6     = 4'd7,
        st_d7     = 4'd8,
        st_parity = 4'd9,
        st_stop   = 4'd10
    } frame_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decoded key event.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [7:0] code;
        logic       extended;  // Preceded by E0.
        logic       released;  // Preceded by F0.
    } key_event_t;

    // Scan code prefixes.
    localparam logic [7:0] scan_prefix_ext   = 8'hE0;
    localparam logic [7:0] scan_prefix_break = 8'hF0;

endpackage

//--- design/ps2_rx_top.sv
`timescale 1ns/1ps

module ps2_rx_top
    import ps2_pkg::*;
#(
    parameter int SYNC_STAGES     = 2,
    parameter int FILTER_LEN      = 8,
    parameter int WATCHDOG_CYCLES = 2000
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       key_valid,
    output logic [7:0] key_code,
    output logic       key_extended,
    output logic       key_release,
    output logic       frame_error
);

    ps2_frame_if frame_bus ();

    logic [7:0] data_byte;
    logic       frame_done;
    key_event_t key;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sync, frame control, shift, decode.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ps2_line_sync #(
        .SYNC_STAGES (SYNC_STAGES),
        .FILTER_LEN  (FILTER_LEN)
    ) ps2_line_sync_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .sample   (frame_bus.sample),
        .data_bit (frame_bus.data_bit)
    );

    ps2_frame_ctrl #(
        .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
    ) ps2_frame_ctrl_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus         (frame_bus.ctrl),
        .frame_done  (frame_done),
        .frame_error (frame_error)
    );

    ps2_frame_shift ps2_frame_shift_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus       (frame_bus.shift),
        .data_byte (data_byte)
    );

    ps2_scan_decoder ps2_scan_decoder_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .frame_done  (frame_done),
        .frame_error (frame_error),
        .data_byte   (data_byte),
        .key_valid   (key_valid),
        .key         (key)
    );

    assign key_code     = key.code;
    assign key_extended = key.extended;
    assign key_release  = key.released;

endmodule

//--- design/ps2_scan_decoder.sv
`timescale 1ns/1ps

module ps2_scan_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       frame_done,
    input  logic       frame_error,
    input  logic [7:0] data_byte,
    output logic       key_valid,
    output key_event_t key
);

    logic ext_pend;
    logic brk_pend;
    logic is_ext;
    logic is_brk;

    assign is_ext = (data_byte == scan_prefix_ext);
    assign is_brk = (data_byte == scan_prefix_break);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Prefix tracking.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ext_pend <= 1'b0;
            brk_pend <= 1'b0;
        end else if (frame_error) begin
            // A broken sequence must not carry into the next key.
            ext_pend <= 1'b0;
            brk_pend <= 1'b0;
        end else if (frame_done) begin
            if (is_ext) begin
                ext_pend <= 1'b1;
            end else if (is_brk) begin
                brk_pend <= 1'b1;
            end else begin
                ext_pend <= 1'b0;  // Consumed by this key.
                brk_pend <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Key event output.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_valid <= 1'b0;
            key       <= '0;
        end else begin
            key_valid <= 1'b0;
            if (frame_done && !is_ext && !is_brk) begin
                key_valid    <= 1'b1;
                key.code     <= data_byte;
                key.extended <= ext_pend;
                key.released <= brk_pend;
            end
        end
    end

endmodule

//--- flist.f
design/ps2_pkg.sv
design/ps2_frame_if.sv
design/ps2_line_sync.sv
design/ps2_frame_ctrl.sv
design/ps2_frame_shift.sv
design/ps2_scan_decoder.sv
design/ps2_rx_top.sv
sim/ps2_rx_checker.sv
sim/ps2_rx_tb.sv

//--- sim/ps2_rx_checker.sv
`timescale 1ns/1ps

module ps2_rx_checker (
    input logic         clk,
    input logic         arst_n,
    input logic         key_valid,
    input logic [7:0]   key_code,
    input logic         key_extended,
    input logic         key_release,
    input logic         frame_error,
    input logic         frame_done,
    input logic         sample,
    input logic         clear,
    input logic         shift_en
);

    logic [3:0] bit_cnt;  // Frame bits seen so far, start bit counts as one.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bit position of the frame in progress.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '0;
        end else if (clear) begin
            bit_cnt <= 4'd1;
        end else if (frame_done || frame_error) begin
            bit_cnt <= '0;  // Frame over or aborted.
        end else if (sample && bit_cnt != '0) begin
            bit_cnt <= bit_cnt + 4'd1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Output strobes.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_valid_vs_error: assert property (@(posedge clk) disable iff (!arst_n)
        !(key_valid && frame_error)) else $error("key_valid and frame_error high together.");

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        key_valid |=> !key_valid) else $error("key_valid longer than one cycle.");
    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        frame_done |=> !frame_done) else $error("frame_done longer than one cycle.");
    a_error_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        frame_error |=> !frame_error) else $error("frame_error longer than one cycle.");

    // Data bits are the eight strobes after the start bit.
    a_shift_bits: assert property (@(posedge clk) disable iff (!arst_n)
        shift_en |-> (bit_cnt >= 4'd1 && bit_cnt <= 4'd8))
        else $error("shift_en outside the data bits.");

    // Outputs held low in reset.
    a_reset_outputs: assert property (@(posedge clk)
        !arst_n |-> (!key_valid && !frame_error && key_code == 8'h00
                     && !key_extended && !key_release))
        else $error("Outputs not low during reset.");

endmodule

bind ps2_rx_top ps2_rx_checker ps2_rx_checker_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .key_valid    (key_valid),
    .key_code     (key_code),
    .key_extended (key_extended),
    .key_release  (key_release),
    .frame_error  (frame_error),
    .frame_done   (frame_done),
    .sample       (frame_bus.sample),
    .clear        (frame_bus.clear),
    .shift_en     (frame_bus.shift_en)
);

//--- sim/ps2_rx_tb.sv
`timescale 1ns/1ps

module ps2_rx_tb
    import ps2_pkg::*;
();

    localparam logic [31:0] SEED          = 32'h748d957a;
    localparam int BIT_CYCLES      = 80;
    localparam int HALF_CYCLES     = BIT_CYCLES / 2;
    localparam int FILTER_LEN      = 8;
    localparam int WATCHDOG_CYCLES = 2000;
    localparam int SETTLE          = 20;
    localparam int N_PLAIN         = 300;
    localparam int N_PREFIX_SEQ    = 40;
    localparam int N_PARITY        = 10;
    localparam int N_STOP          = 10;
    localparam int N_CUT           = 10;
    localparam int N_GLITCH        = 50;
    localparam int N_FRAMES        = N_PLAIN + 3 * N_PREFIX_SEQ + 4 * N_PARITY
                                   + 2 * N_STOP + 2 * N_CUT + N_GLITCH;
    // Each frame plus its idle bit and settle time, plus the watchdog gaps.
    localparam int TIMEOUT_CYCLES  = N_FRAMES * (12 * BIT_CYCLES + SETTLE)
                                   + N_CUT * (WATCHDOG_CYCLES + SETTLE) + 5000;

    logic       clk;
    logic       arst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       key_valid;
    logic [7:0] key_code;
    logic       key_extended;
    logic       key_release;
    logic       frame_error;

    key_event_t exp_keys[$];  // Expected events in order.
    key_event_t exp_key;
    key_event_t got_key;
    logic       pend_ext;
    logic       pend_brk;
    int         err_exp;
    int         err_seen;
    int         cycles;

    ps2_rx_top #(
        .SYNC_STAGES     (2),
        .FILTER_LEN      (FILTER_LEN),
        .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
    ) ps2_rx_top_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .key_valid    (key_valid),
        .key_code     (key_code),
        .key_extended (key_extended),
        .key_release  (key_release),
        .frame_error  (frame_error)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on first error.");
    endtask

    task automatic check_key(input key_event_t exp, input key_event_t got);
        if (got !== exp) begin
            fail_run($sformatf({"CHECK FAILED at %0t ns: key expected code=%02h ext=%0b rel=%0b,",
                " got code=%02h ext=%0b rel=%0b"}, $time, exp.code, exp.extended,
                exp.released, got.code, got.extended, got.released));
        end
    endtask

    task automatic check_error(input int exp, input int got);
        if (got != exp) begin
            fail_run($sformatf("CHECK FAILED at %0t ns: frame_error count expected %0d, got %0d",
                $time, exp, got));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model of the prefix rule.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_byte(input logic [7:0] b);
        if (b == scan_prefix_ext) begin
            pend_ext = 1'b1;
        end else if (b == scan_prefix_break) begin
            pend_brk = 1'b1;
        end else begin
            exp_keys.push_back(key_event_t'{code: b, extended: pend_ext, released: pend_brk});
            pend_ext = 1'b0;
            pend_brk = 1'b0;
        end
    endtask

    task automatic model_error();
        err_exp++;
        pend_ext = 1'b0;  // Broken sequence drops prefixes.
        pend_brk = 1'b0;
    endtask

    // Wait n rising edges, then step off the edge.
    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // Drives the first nbits bits of a frame, as a keyboard would.
    task automatic send_frame(input logic [7:0] b, input bit bad_par, input bit bad_stop,
                              input int nbits, input bit glitch);
        logic [10:0] fr;
        int          p;
        fr = {~bad_stop, ~^b ^ bad_par, b, 1'b0};
        for (int i = 0; i < nbits; i++) begin
            ps2_data = fr[i];  // Data moves while the clock is high.
            if (glitch && ($urandom % 2 == 0)) begin
                p = 1 + int'($urandom % (FILTER_LEN - 1));
                tick(10);
                ps2_clk = 1'b0;
                tick(p);
                ps2_clk = 1'b1;
                tick(HALF_CYCLES - 10 - p);
            end else begin
                tick(HALF_CYCLES);
            end
            ps2_clk = 1'b0;
            tick(HALF_CYCLES);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        tick(BIT_CYCLES);
    endtask

    task automatic send_good(input logic [7:0] b, input bit glitch);
        model_byte(b);
        send_frame(b, 1'b0, 1'b0, 11, glitch);
    endtask

    task automatic send_prefixes();
        case ($urandom % 3)
            0: send_good(scan_prefix_ext, 1'b0);
            1: send_good(scan_prefix_break, 1'b0);
            default: begin
                send_good(scan_prefix_ext, 1'b0);
                send_good(scan_prefix_break, 1'b0);
            end
        endcase
    endtask

    function automatic logic [7:0] rand_plain();
        logic [7:0] b;
        do begin
            b = 8'($urandom);
        end while (b == scan_prefix_ext || b == scan_prefix_break);
        return b;
    endfunction

    // Wait for all expected results, then look for strays.
    task automatic wait_results();
        while (exp_keys.size() != 0 || err_seen < err_exp) tick(1);
        tick(SETTLE);
        check_error(err_exp, err_seen);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Monitor and timeout.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (arst_n) begin
            if (frame_error) err_seen++;
            if (key_valid) begin
                got_key = key_event_t'({key_code, key_extended, key_release});
                if (exp_keys.size() == 0) begin
                    fail_run($sformatf("Unexpected key event with code %02h at %0t ns",
                        key_code, $time));
                end else begin
                    exp_key = exp_keys.pop_front();
                    check_key(exp_key, got_key);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout after %0d cycles, %0d expected key events never arrived",
                cycles, exp_keys.size()));
        end
    end

    initial begin
        int cut;
        void'($urandom(SEED));
        clk      = 1'b0;
        arst_n   = 1'b0;
        ps2_clk  = 1'b1;  // Idle bus.
        ps2_data = 1'b1;
        pend_ext = 1'b0;
        pend_brk = 1'b0;
        err_exp  = 0;
        err_seen = 0;
        cycles   = 0;
        tick(5);
        arst_n = 1'b1;
        tick(SETTLE);

        for (int n = 0; n < N_PLAIN; n++) begin
            send_good(rand_plain(), 1'b0);
            wait_results();
        end
        for (int n = 0; n < N_PREFIX_SEQ; n++) begin
            send_prefixes();
            send_good(rand_plain(), 1'b0);
            wait_results();
        end
        for (int n = 0; n < N_PARITY; n++) begin
            send_prefixes();
            send_frame(8'($urandom), 1'b1, 1'b0, 11, 1'b0);
            model_error();
            wait_results();
            send_good(rand_plain(), 1'b0);
            wait_results();
        end
        for (int n = 0; n < N_STOP; n++) begin
            send_frame(rand_plain(), 1'b0, 1'b1, 11, 1'b0);
            model_error();
            wait_results();
            send_good(rand_plain(), 1'b0);
            wait_results();
        end
        for (int n = 0; n < N_CUT; n++) begin
            cut = 1 + int'($urandom % 10);
            send_frame(8'($urandom), 1'b0, 1'b0, cut, 1'b0);
            model_error();
            wait_results();  // Watchdog fires during this wait.
            send_good(rand_plain(), 1'b0);
            wait_results();
        end
        for (int n = 0; n < N_GLITCH; n++) begin
            send_good(8'($urandom), 1'b1);
            wait_results();
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
